// File: Makefile
# Verilator build and run of the ULA testbench

VERILATOR  ?= verilator
TOP        ?= ula_tb
FILELIST   ?= ula_top.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: design/cpu_timing.sv
`timescale 1ns/1ps
`include "ula_cfg.svh"

module cpu_timing (
	input  logic                  clk28,
	input  logic                  rst_n,
	input  logic                  cpu_phase,
	input  ula_pkg::raster_pos_t  pos,
	input  ula_pkg::timing_mode_t mode,
	output logic                  clkcpu,
	output logic                  cpu_tick,
	output logic                  n_int
);
	import ula_pkg::*;

	logic [4:0] int_cnt;
	logic [8:0] int_v;
	logic [8:0] int_h;
	logic       int_begin;

	always_comb begin
		case (mode)
			pent: begin
				int_v = 9'(`ULA_INT_V_PENT);
				int_h = 9'(`ULA_INT_H_PENT);
			end
			s128: begin
				int_v = 9'(`ULA_INT_V_S128);
				int_h = 9'(`ULA_INT_H_S128);
			end
			default: begin
				int_v = 9'(`ULA_INT_V_S48);
				int_h = 9'(`ULA_INT_H_S48);
			end
		endcase
	end

	assign int_begin = pos.vc == int_v && pos.hc == int_h;
	assign cpu_tick  = cpu_phase & ~clkcpu;  // clkcpu rises at this edge

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			clkcpu  <= 1'b0;
			int_cnt <= '0;
			n_int   <= 1'b1;
		end else begin
			clkcpu <= cpu_phase;
			if (cpu_tick)
				n_int <= int_cnt == 5'd0;
			if (int_cnt == 5'd0 && int_begin)
				int_cnt <= 5'd1;
			else if (int_cnt != 5'd0 && cpu_tick)
				int_cnt <= (int_cnt == 5'(`ULA_INT_TICKS)) ? 5'd0 : int_cnt + 5'd1;
		end
	end

endmodule

// File: design/io_ports.sv
`timescale 1ns/1ps
`include "ula_cfg.svh"

module io_ports (
	input  logic             clk28,
	input  logic             rst_n,
	input  logic             cpu_tick,
	input  logic             io_valid,
	output logic             io_ready,
	input  ula_pkg::io_req_t io_req,
	output logic [7:0]       io_rdata,
	output logic             io_rvalid,
	input  logic [4:0]       kd,
	input  logic             tape_in,
	output logic [2:0]       border,
	output logic             beeper,
	output logic             tape_out
);

	logic xfer;
	logic fe_sel;

	assign io_ready = cpu_tick;         // keeps border writes on the cpu clock
	assign xfer     = io_valid & io_ready;
	assign fe_sel   = ~io_req.addr[`ULA_FE_ADDR_BIT];

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			io_rvalid <= 1'b0;
			border    <= 3'd0;
			beeper    <= 1'b0;
			tape_out  <= 1'b0;
		end else begin
			io_rvalid <= xfer && fe_sel && !io_req.wr;
			if (xfer && fe_sel && io_req.wr) begin
				beeper   <= io_req.wdata[4];
				tape_out <= io_req.wdata[3];
				border   <= io_req.wdata[2:0];
			end
		end
	end

	always_ff @(posedge clk28) begin
		if (xfer && fe_sel && !io_req.wr)
			io_rdata <= {1'b1, tape_in, 1'b1, kd};
	end

endmodule

// File: design/pixel_out.sv
`timescale 1ns/1ps
`include "ula_cfg.svh"

module pixel_out (
	input  logic                 clk28,
	input  logic                 rst_n,
	input  ula_pkg::vid_strobe_t strb,
	input  ula_pkg::sync_t       sync,
	input  logic [2:0]           border,
	input  logic [7:0]           bitmap_next,
	input  logic [7:0]           attr_next,
	input  logic                 frame_int_n,
	output ula_pkg::rgb_t        rgb,
	output logic                 csync,
	output logic                 hsync,
	output logic                 vsync
);

	logic [7:0]                 bitmap;
	logic [7:0]                 attr;
	logic [`ULA_BLINK_BITS-1:0] blink_cnt;
	logic                       int_q;
	logic                       pixel;
	logic [2:0]                 col;    // g r b
	logic                       bright;

	assign pixel  = bitmap[7] ^ (attr[7] & blink_cnt[`ULA_BLINK_BITS-1]);
	assign col    = pixel ? attr[2:0] : attr[5:3];
	assign bright = attr[6];

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			int_q     <= 1'b1;
			blink_cnt <= '0;
		end else begin
			int_q <= frame_int_n;
			if (int_q && !frame_int_n)
				blink_cnt <= blink_cnt + 1'b1;  // once per frame
		end
	end

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			bitmap <= '0;
			attr   <= '0;
		end else begin
			if (strb.border_update)
				attr <= {2'b00, border, 3'b000};  // border as paper
			else if (strb.screen_update)
				attr <= attr_next;
			if (strb.screen_update)
				bitmap <= bitmap_next;
			else if (strb.bitmap_shift)
				bitmap <= {bitmap[6:0], 1'b0};
		end
	end

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			rgb   <= '0;
			csync <= 1'b1;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			if (sync.blank)
				rgb <= '0;
			else
				rgb <= {col[2], col[2] & bright, col[1], col[1] & bright,
					col[0], col[0] & bright};
			csync <= ~(sync.vsync ^ sync.hsync);
			hsync <= sync.hsync;
			vsync <= sync.vsync;
		end
	end

endmodule

// File: design/screen_fetch.sv
`timescale 1ns/1ps

module screen_fetch (
	input  logic                 clk28,
	input  logic                 rst_n,
	input  ula_pkg::raster_pos_t pos,
	input  ula_pkg::vid_strobe_t strb,
	input  logic                 ck14,
	output logic [13:0]          vram_addr,
	output logic                 vram_rd,
	input  logic [7:0]           vram_data,
	output logic [7:0]           bitmap_next,
	output logic [7:0]           attr_next
);

	logic        attr_phase;        // second slot of the group
	logic [13:0] bitmap_addr;
	logic [13:0] attr_addr;

	// spectrum interleave, thirds / pixel row / char row / column
	assign bitmap_addr = {1'b0, pos.vc[7:6], pos.vc[2:0], pos.vc[5:3], pos.hc[7:3]};
	assign attr_addr   = {4'b0110, pos.vc[7:3], pos.hc[7:3]};  // 0x1800 base
	assign vram_addr   = attr_phase ? attr_addr : bitmap_addr;

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			vram_rd    <= 1'b0;
			attr_phase <= 1'b0;
		end else if (ck14) begin
			if (strb.fetch_slot_end) begin
				vram_rd    <= strb.screen_load;
				attr_phase <= 1'b0;
			end else if (vram_rd) begin
				attr_phase <= ~attr_phase;
				if (attr_phase)
					vram_rd <= 1'b0;   // both bytes in
			end
		end
	end

	// data is sampled on the last clk28 of each slot
	always_ff @(posedge clk28) begin
		if (ck14 && vram_rd) begin
			if (attr_phase)
				attr_next <= vram_data;
			else
				bitmap_next <= vram_data;
		end
	end

endmodule

// File: design/ula_cfg.svh
`ifndef ULA_CFG_SVH
`define ULA_CFG_SVH

`define ULA_H_AREA        256
`define ULA_V_AREA        192
`define ULA_SCREEN_DELAY  8

// pentagon
`define ULA_H_LBORDER_PENT  (64 - `ULA_SCREEN_DELAY)
`define ULA_H_RBORDER_PENT  (56 + `ULA_SCREEN_DELAY)
`define ULA_H_BLANK1_PENT   8
`define ULA_H_SYNC_PENT     33
`define ULA_H_BLANK2_PENT   31
`define ULA_V_BBORDER_PENT  56
`define ULA_V_SYNC_PENT     8
`define ULA_V_TBORDER_PENT  64

// 128k
`define ULA_H_LBORDER_S128  (64 - `ULA_SCREEN_DELAY)
`define ULA_H_RBORDER_S128  (60 + `ULA_SCREEN_DELAY)
`define ULA_H_BLANK1_S128   16
`define ULA_H_SYNC_S128     33
`define ULA_H_BLANK2_S128   27
`define ULA_V_BBORDER_S128  47
`define ULA_V_SYNC_S128     8
`define ULA_V_TBORDER_S128  64

// 48k
`define ULA_H_LBORDER_S48   (48 - `ULA_SCREEN_DELAY)
`define ULA_H_RBORDER_S48   (48 + `ULA_SCREEN_DELAY)
`define ULA_H_BLANK1_S48    16
`define ULA_H_SYNC_S48      33
`define ULA_H_BLANK2_S48    47
`define ULA_V_BBORDER_S48   48
`define ULA_V_SYNC_S48      8
`define ULA_V_TBORDER_S48   64

// pixels per line, lines per frame
`define ULA_H_TOTAL_PENT (`ULA_H_AREA + `ULA_H_RBORDER_PENT + `ULA_H_BLANK1_PENT + \
	`ULA_H_SYNC_PENT + `ULA_H_BLANK2_PENT + `ULA_H_LBORDER_PENT)
`define ULA_H_TOTAL_S128 (`ULA_H_AREA + `ULA_H_RBORDER_S128 + `ULA_H_BLANK1_S128 + \
	`ULA_H_SYNC_S128 + `ULA_H_BLANK2_S128 + `ULA_H_LBORDER_S128)
`define ULA_H_TOTAL_S48 (`ULA_H_AREA + `ULA_H_RBORDER_S48 + `ULA_H_BLANK1_S48 + \
	`ULA_H_SYNC_S48 + `ULA_H_BLANK2_S48 + `ULA_H_LBORDER_S48)
`define ULA_V_TOTAL_PENT (`ULA_V_AREA + `ULA_V_BBORDER_PENT + `ULA_V_SYNC_PENT + \
	`ULA_V_TBORDER_PENT)
`define ULA_V_TOTAL_S128 (`ULA_V_AREA + `ULA_V_BBORDER_S128 + `ULA_V_SYNC_S128 + \
	`ULA_V_TBORDER_S128)
`define ULA_V_TOTAL_S48 (`ULA_V_AREA + `ULA_V_BBORDER_S48 + `ULA_V_SYNC_S48 + \
	`ULA_V_TBORDER_S48)

// frame interrupt position
`define ULA_INT_V_PENT   239
`define ULA_INT_H_PENT   318
`define ULA_INT_V_S128   247
`define ULA_INT_H_S128   (`ULA_H_TOTAL_S128 - 6)
`define ULA_INT_V_S48    247
`define ULA_INT_H_S48    (`ULA_H_TOTAL_S48 - 6)

`define ULA_INT_TICKS    31
`define ULA_BLINK_BITS   5
`define ULA_FE_ADDR_BIT  0

`endif

// File: design/ula_pkg.sv
package ula_pkg;

	typedef enum logic [1:0] {
		pent = 2'b00,
		s128 = 2'b01,
		s48  = 2'b11
	} timing_mode_t;

	typedef struct packed {
		logic [8:0] vc;             // line
		logic [8:0] hc;             // character pixel
	} raster_pos_t;

	typedef struct packed {
		logic screen_load;
		logic screen_show;
		logic screen_update;
		logic border_update;
		logic bitmap_shift;
		logic fetch_slot_end;       // last clk28 of 8-pixel group
	} vid_strobe_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic blank;
	} sync_t;

	typedef struct packed {
		logic [1:0] g;              // {colour, bright}
		logic [1:0] r;
		logic [1:0] b;
	} rgb_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        wr;
	} io_req_t;

endpackage

// File: design/ula_top.sv
`timescale 1ns/1ps

module ula_top (
	input  logic                  clk28,
	input  logic                  rst_n,
	input  ula_pkg::timing_mode_t mode,
	output logic [13:0]           vram_addr,
	output logic                  vram_rd,
	input  logic [7:0]            vram_data,
	input  logic                  io_valid,
	output logic                  io_ready,
	input  ula_pkg::io_req_t      io_req,
	output logic [7:0]            io_rdata,
	output logic                  io_rvalid,
	input  logic [4:0]            kd,
	input  logic                  tape_in,
	output ula_pkg::rgb_t         rgb,
	output logic                  csync,
	output logic                  hsync,
	output logic                  vsync,
	output logic                  clkcpu,
	output logic                  n_int,
	output logic                  beeper,
	output logic                  tape_out
);
	import ula_pkg::*;

	raster_pos_t pos;
	vid_strobe_t strb;
	sync_t       sync;
	logic        ck14;
	logic        cpu_phase;
	logic [7:0]  bitmap_next;
	logic [7:0]  attr_next;
	logic        cpu_tick;
	logic [2:0]  border;

	video_timing u_video_timing (
		.clk28     (clk28),
		.rst_n     (rst_n),
		.mode      (mode),
		.pos       (pos),
		.strb      (strb),
		.sync      (sync),
		.ck14      (ck14),
		.cpu_phase (cpu_phase)
	);

	screen_fetch u_screen_fetch (
		.clk28       (clk28),
		.rst_n       (rst_n),
		.pos         (pos),
		.strb        (strb),
		.ck14        (ck14),
		.vram_addr   (vram_addr),
		.vram_rd     (vram_rd),
		.vram_data   (vram_data),
		.bitmap_next (bitmap_next),
		.attr_next   (attr_next)
	);

	pixel_out u_pixel_out (
		.clk28       (clk28),
		.rst_n       (rst_n),
		.strb        (strb),
		.sync        (sync),
		.border      (border),
		.bitmap_next (bitmap_next),
		.attr_next   (attr_next),
		.frame_int_n (n_int),
		.rgb         (rgb),
		.csync       (csync),
		.hsync       (hsync),
		.vsync       (vsync)
	);

	cpu_timing u_cpu_timing (
		.clk28     (clk28),
		.rst_n     (rst_n),
		.cpu_phase (cpu_phase),
		.pos       (pos),
		.mode      (mode),
		.clkcpu    (clkcpu),
		.cpu_tick  (cpu_tick),
		.n_int     (n_int)
	);

	io_ports u_io_ports (
		.clk28     (clk28),
		.rst_n     (rst_n),
		.cpu_tick  (cpu_tick),
		.io_valid  (io_valid),
		.io_ready  (io_ready),
		.io_req    (io_req),
		.io_rdata  (io_rdata),
		.io_rvalid (io_rvalid),
		.kd        (kd),
		.tape_in   (tape_in),
		.border    (border),
		.beeper    (beeper),
		.tape_out  (tape_out)
	);

endmodule

// File: design/video_timing.sv
`timescale 1ns/1ps
`include "ula_cfg.svh"

module video_timing (
	input  logic                  clk28,
	input  logic                  rst_n,
	input  ula_pkg::timing_mode_t mode,
	output ula_pkg::raster_pos_t  pos,
	output ula_pkg::vid_strobe_t  strb,
	output ula_pkg::sync_t        sync,
	output logic                  ck14,
	output logic                  cpu_phase
);
	import ula_pkg::*;

	logic [10:0] hc0;               // 4 clk28 per pixel
	logic [8:0]  vc;
	logic [8:0]  hc;
	logic [10:0] h_last;
	logic [10:0] hb_start;
	logic [10:0] hs_start;
	logic [10:0] hs_end;
	logic [10:0] hb_end;
	logic [8:0]  v_last;
	logic [8:0]  vs_start;
	logic [8:0]  vs_end;
	logic        hc0_end;
	logic        vc_end;
	logic        in_rows;
	logic        ck7;

	always_comb begin
		case (mode)
			pent: begin
				h_last   = 11'(`ULA_H_TOTAL_PENT * 4 - 1);
				hb_start = 11'(`ULA_H_AREA + `ULA_H_RBORDER_PENT);
				hs_start = hb_start + 11'(`ULA_H_BLANK1_PENT);
				hs_end   = hs_start + 11'(`ULA_H_SYNC_PENT);
				hb_end   = hs_end + 11'(`ULA_H_BLANK2_PENT);
				v_last   = 9'(`ULA_V_TOTAL_PENT - 1);
				vs_start = 9'(`ULA_V_AREA + `ULA_V_BBORDER_PENT);
				vs_end   = vs_start + 9'(`ULA_V_SYNC_PENT);
			end
			s128: begin
				h_last   = 11'(`ULA_H_TOTAL_S128 * 4 - 1);
				hb_start = 11'(`ULA_H_AREA + `ULA_H_RBORDER_S128);
				hs_start = hb_start + 11'(`ULA_H_BLANK1_S128);
				hs_end   = hs_start + 11'(`ULA_H_SYNC_S128);
				hb_end   = hs_end + 11'(`ULA_H_BLANK2_S128);
				v_last   = 9'(`ULA_V_TOTAL_S128 - 1);
				vs_start = 9'(`ULA_V_AREA + `ULA_V_BBORDER_S128);
				vs_end   = vs_start + 9'(`ULA_V_SYNC_S128);
			end
			default: begin          // 48k and the unused code
				h_last   = 11'(`ULA_H_TOTAL_S48 * 4 - 1);
				hb_start = 11'(`ULA_H_AREA + `ULA_H_RBORDER_S48);
				hs_start = hb_start + 11'(`ULA_H_BLANK1_S48);
				hs_end   = hs_start + 11'(`ULA_H_SYNC_S48);
				hb_end   = hs_end + 11'(`ULA_H_BLANK2_S48);
				v_last   = 9'(`ULA_V_TOTAL_S48 - 1);
				vs_start = 9'(`ULA_V_AREA + `ULA_V_BBORDER_S48);
				vs_end   = vs_start + 9'(`ULA_V_SYNC_S48);
			end
		endcase
	end

	assign hc0_end = hc0 >= h_last;     // >= recovers from a mode change
	assign vc_end  = vc >= v_last;

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			hc0 <= '0;
			vc  <= '0;
		end else if (hc0_end) begin
			hc0 <= '0;
			vc  <= vc_end ? 9'd0 : vc + 9'd1;
		end else begin
			hc0 <= hc0 + 11'd1;
		end
	end

	assign hc        = hc0[10:2];
	assign ck14      = hc0[0];
	assign ck7       = hc0[1] & hc0[0];
	assign cpu_phase = hc0[2];
	assign in_rows   = vc < 9'(`ULA_V_AREA);
	assign pos       = {vc, hc};

	always_comb begin
		// fetch for the next group, crossing into the next line at wrap
		strb.screen_load = hc0_end ? (vc_end || vc < 9'(`ULA_V_AREA - 1)) :
			(in_rows && hc < 9'(`ULA_H_AREA - 8));
		strb.screen_show = in_rows && hc0 >= 11'(`ULA_SCREEN_DELAY * 4 - 2) &&
			hc0 < 11'((`ULA_H_AREA + `ULA_SCREEN_DELAY) * 4 - 2);
		strb.screen_update = in_rows && hc < 9'(`ULA_H_AREA) && hc0[4:0] == 5'b11110;
		strb.border_update = !strb.screen_show &&
			((mode == pent && ck7) || hc0[4:0] == 5'b11110);
		strb.bitmap_shift   = hc0[1:0] == 2'b10;
		strb.fetch_slot_end = hc0[4:0] == 5'b11111 || hc0_end;

		sync.hsync = hc >= hs_start && hc < hs_end;
		sync.vsync = vc >= vs_start && vc < vs_end;
		sync.blank = sync.vsync || (hc >= hb_start && hc < hb_end);
	end

endmodule

// File: ula_top.f
+incdir+design
+incdir+verif
design/ula_pkg.sv
design/video_timing.sv
design/screen_fetch.sv
design/pixel_out.sv
design/cpu_timing.sv
design/io_ports.sv
design/ula_top.sv
verif/ula_assert.sv
verif/ula_tb.sv

// File: verif/ula_assert.sv
`timescale 1ns/1ps
`include "ula_cfg.svh"

module ula_assert (
	input logic             clk28,
	input logic             rst_n,
	input logic             io_valid,
	input logic             io_ready,
	input ula_pkg::io_req_t io_req,
	input logic             io_rvalid,
	input logic             hsync,
	input logic             vsync,
	input ula_pkg::rgb_t    rgb
);

	rvalid_after_read: assert property (@(posedge clk28) disable iff (!rst_n)
		io_rvalid |-> $past(io_valid && io_ready && !io_req.wr &&
			!io_req.addr[`ULA_FE_ADDR_BIT]))
		else $error("io_rvalid without an accepted read of port FE");

	hsync_apart_from_vsync: assert property (@(posedge clk28) disable iff (!rst_n)
		!($rose(hsync) && $changed(vsync)))
		else $error("hsync rose in the cycle vsync changed");

	// sync pulses lie inside the blanking intervals
	black_in_sync: assert property (@(posedge clk28) disable iff (!rst_n)
		(hsync || vsync) |-> rgb == '0)
		else $error("rgb not black during sync");

endmodule

bind ula_top ula_assert u_ula_assert (
	.clk28     (clk28),
	.rst_n     (rst_n),
	.io_valid  (io_valid),
	.io_ready  (io_ready),
	.io_req    (io_req),
	.io_rvalid (io_rvalid),
	.hsync     (hsync),
	.vsync     (vsync),
	.rgb       (rgb)
);

// File: verif/ula_tests.svh
`ifndef ULA_TESTS_SVH
`define ULA_TESTS_SVH

// line period, hsync width, lines per frame, vsync width
task automatic check_raster(input timing_mode_t m);
	int   n;
	int   high;
	int   low;
	int   lines;
	int   sync_low;
	logic prev_h;
	logic prev_v;
	apply_reset(m);
	wait_edge(SEL_HSYNC, 1'b1, n);
	wait_edge(SEL_HSYNC, 1'b0, high);
	wait_edge(SEL_HSYNC, 1'b1, low);
	check_value("hsync width", high, 132);
	check_value("hsync period", high + low, line_cycles(m));
	wait_edge(SEL_VSYNC, 1'b1, n);
	lines    = 0;
	high     = 0;
	sync_low = 0;
	prev_h   = hsync;
	prev_v   = vsync;
	forever begin
		@(posedge clk28);
		if (vsync)
			high++;
		if (!csync)
			sync_low++;
		if (hsync && !prev_h)
			lines++;
		if (vsync && !prev_v)
			break;
		prev_h = hsync;
		prev_v = vsync;
	end
	check_value("hsync rises per frame", lines, frame_lines(m));
	check_value("vsync width", high, 8 * line_cycles(m));
	// hsync outside vsync lines plus vsync outside hsync
	check_value("csync low time", sync_low,
		(frame_lines(m) - 8) * 132 + 8 * (line_cycles(m) - 132));
endtask

task automatic check_frame_int();
	int n;
	int low;
	int rest;
	int period;
	wait_edge(SEL_CLKCPU, 1'b1, n);
	wait_edge(SEL_CLKCPU, 1'b1, period);
	check_value("clkcpu period", period, 8);
	wait_edge(SEL_NINT, 1'b0, n);
	wait_edge(SEL_NINT, 1'b1, low);
	wait_edge(SEL_NINT, 1'b0, rest);
	check_value("n_int low time", low, `ULA_INT_TICKS * 8);
	check_value("n_int period", low + rest, line_cycles(mode) * frame_lines(mode));
endtask

task automatic check_border_write();
	logic [31:0] r;
	logic [7:0]  d;
	int          n;
	repeat (4) begin
		r = rand_next();
		d = r[23:16];
		bus_access({r[15:1], 1'b0}, d, 1'b1);
		do begin                         // left border of a line outside vsync
			wait_edge(SEL_HSYNC, 1'b0, n);
			repeat (BORDER_OFS) @(posedge clk28);
		end while (vsync);
		check_value("rgb", 32'(rgb), 32'(rgb_of(d[2:0], 1'b0)));
		check_value("beeper", 32'(beeper), 32'(d[4]));
		check_value("tape_out", 32'(tape_out), 32'(d[3]));
	end
endtask

task automatic check_port_read();
	logic [31:0] r;
	logic [4:0]  keys;
	logic        tape;
	int          waited;
	r = 32'd0;
	repeat (4) begin
		r       = rand_next();
		keys    = r[20:16];
		tape    = r[21];
		kd      <= keys;
		tape_in <= tape;
		@(posedge clk28);
		bus_access({r[15:1], 1'b0}, 8'h00, 1'b0);
		waited = 0;
		do begin
			@(posedge clk28);
			waited++;
			if (!io_rvalid && waited >= 2)
				stop_with_failure("no io_rvalid after a read of port FE");
		end while (!io_rvalid);
		check_value("io_rdata", 32'(io_rdata), 32'({1'b1, tape, 1'b1, keys}));
	end
	bus_access({r[15:1], 1'b1}, 8'h00, 1'b0);  // odd address
	repeat (16) begin
		@(posedge clk28);
		if (io_rvalid)
			stop_with_failure("io_rvalid came after a read at an odd address");
	end
endtask

task automatic check_screen_pixel();
	logic [7:0] attr;
	int         n;
	attr = 8'h45;                        // bright, paper 0, ink 5
	for (int a = 'h1800; a < 'h1b00; a++)
		vram[a] = attr;
	wait_edge(SEL_VSYNC, 1'b0, n);
	repeat (`ULA_V_TBORDER_PENT + 96) wait_edge(SEL_HSYNC, 1'b1, n);
	// on to pixel 128 of row 96
	repeat (4 * (`ULA_H_TOTAL_PENT - HS_START_PENT + 128)) @(posedge clk28);
	check_value("rgb", 32'(rgb), 32'(rgb_of(attr[2:0], attr[6])));
endtask

`endif

// File: verif/ula_tb.sv
`timescale 1ns/1ps
`include "ula_cfg.svh"

module ula_tb;
	import ula_pkg::*;

	localparam int FRAME_MAX      = 4 * `ULA_H_TOTAL_PENT * `ULA_V_TOTAL_PENT;
	localparam int TIMEOUT_CYCLES = 12 * FRAME_MAX;  // about nine frames of tests
	localparam int HS_START_PENT  = `ULA_H_AREA + `ULA_H_RBORDER_PENT + `ULA_H_BLANK1_PENT;
	localparam int BORDER_OFS     = 4 * (`ULA_H_BLANK2_PENT + `ULA_H_LBORDER_PENT / 2);
	localparam int SEL_HSYNC      = 0;
	localparam int SEL_VSYNC      = 1;
	localparam int SEL_NINT       = 2;
	localparam int SEL_CLKCPU     = 3;

	logic         clk28 = 1'b0;
	logic         rst_n;
	timing_mode_t mode;
	logic [13:0]  vram_addr;
	logic         vram_rd;
	logic [7:0]   vram_data;
	logic         io_valid;
	logic         io_ready;
	io_req_t      io_req;
	logic [7:0]   io_rdata;
	logic         io_rvalid;
	logic [4:0]   kd;
	logic         tape_in;
	rgb_t         rgb;
	logic         csync;
	logic         hsync;
	logic         vsync;
	logic         clkcpu;
	logic         n_int;
	logic         beeper;
	logic         tape_out;
	logic [7:0]   vram [0:16383];
	logic [31:0]  lcg_state = 32'd24;
	int           cycle_cnt = 0;

	ula_top dut (
		.clk28     (clk28),
		.rst_n     (rst_n),
		.mode      (mode),
		.vram_addr (vram_addr),
		.vram_rd   (vram_rd),
		.vram_data (vram_data),
		.io_valid  (io_valid),
		.io_ready  (io_ready),
		.io_req    (io_req),
		.io_rdata  (io_rdata),
		.io_rvalid (io_rvalid),
		.kd        (kd),
		.tape_in   (tape_in),
		.rgb       (rgb),
		.csync     (csync),
		.hsync     (hsync),
		.vsync     (vsync),
		.clkcpu    (clkcpu),
		.n_int     (n_int),
		.beeper    (beeper),
		.tape_out  (tape_out)
	);

	assign vram_data = vram_rd ? vram[vram_addr] : 8'h00;  // answers within the read slot

	always #5 clk28 = ~clk28;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	always @(posedge clk28) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES)
			stop_with_failure("timeout: the tests did not finish within the cycle limit");
	end

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// 2-bit channels, colour then bright
	function automatic logic [5:0] rgb_of(input logic [2:0] c, input logic br);
		return {c[2], c[2] & br, c[1], c[1] & br, c[0], c[0] & br};
	endfunction

	function automatic int line_cycles(input timing_mode_t m);
		case (m)
			pent:    return 4 * `ULA_H_TOTAL_PENT;
			s128:    return 4 * `ULA_H_TOTAL_S128;
			default: return 4 * `ULA_H_TOTAL_S48;
		endcase
	endfunction

	function automatic int frame_lines(input timing_mode_t m);
		case (m)
			pent:    return `ULA_V_TOTAL_PENT;
			s128:    return `ULA_V_TOTAL_S128;
			default: return `ULA_V_TOTAL_S48;
		endcase
	endfunction

	function automatic logic probe(input int sel);
		case (sel)
			SEL_HSYNC: return hsync;
			SEL_VSYNC: return vsync;
			SEL_NINT:  return n_int;
			default:   return clkcpu;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			stop_with_failure($sformatf("** Error: %s is 0x%0h, expected 0x%0h",
				name, got, expected));
	endtask

	task automatic apply_reset(input timing_mode_t m);
		@(posedge clk28);
		rst_n <= 1'b0;
		mode  <= m;
		repeat (3) @(posedge clk28);
		rst_n <= 1'b1;
		@(posedge clk28);
	endtask

	// cycles until the selected output reaches level
	task automatic wait_edge(input int sel, input logic level, output int cycles);
		logic prev;
		logic cur;
		prev   = probe(sel);
		cycles = 0;
		forever begin
			@(posedge clk28);
			cycles++;
			cur = probe(sel);
			if (cur == level && prev != level)
				break;
			prev = cur;
		end
	endtask

	task automatic bus_access(input logic [15:0] a, input logic [7:0] d, input logic wr);
		int waited;
		waited = 0;
		io_req   <= {a, d, wr};
		io_valid <= 1'b1;
		do begin
			@(posedge clk28);
			waited++;
			if (!io_ready && waited >= 8)
				stop_with_failure("io_ready did not come within 8 cycles of io_valid");
		end while (!io_ready);
		io_valid <= 1'b0;
	endtask

	`include "ula_tests.svh"

	initial begin
		rst_n    = 1'b0;
		mode     = pent;
		io_valid = 1'b0;
		io_req   = '0;
		kd       = 5'h1f;
		tape_in  = 1'b0;
		for (int a = 0; a < 16384; a++)
			vram[a] = (a < 'h1800) ? 8'hff : 8'(a ^ (a >> 8));
		check_raster(pent);
		check_raster(s128);
		check_raster(s48);
		apply_reset(pent);               // remaining tests in pentagon timing
		check_frame_int();
		check_border_write();
		check_port_read();
		check_screen_pixel();
		$display("RESULT: PASS");
		$finish;
	end

endmodule
